/* logic/rv_core_pkg.sv */
// Shared definitions for the multi-cycle RV32I core
// Word types, opcode and funct encodings, ALU operations, CSR numbers
// and the instruction word with its decode views
package rv_core_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  // ALU operation code
  typedef logic [3:0]  alu_op_t;

  ////////////////////
  // Opcodes
  ////////////////////

  localparam logic [6:0] OpcodeOpImm  = 7'b0010011;
  localparam logic [6:0] OpcodeOp     = 7'b0110011;
  localparam logic [6:0] OpcodeLoad   = 7'b0000011;
  localparam logic [6:0] OpcodeStore  = 7'b0100011;
  localparam logic [6:0] OpcodeSystem = 7'b1110011;

  // Minor opcode fields
  localparam logic [2:0] Funct3AddSub = 3'b000;
  localparam logic [2:0] Funct3Sll    = 3'b001;
  localparam logic [2:0] Funct3Word   = 3'b010;
  localparam logic [2:0] Funct3Xor    = 3'b100;
  localparam logic [2:0] Funct3Srl    = 3'b101;
  localparam logic [2:0] Funct3Or     = 3'b110;
  localparam logic [2:0] Funct3And    = 3'b111;
  localparam logic [2:0] Funct3Csrrw  = 3'b001;
  localparam logic [6:0] Funct7Sub    = 7'b0100000;

  ////////////////////
  // ALU operations
  ////////////////////

  localparam alu_op_t AluAdd = 4'd0;
  localparam alu_op_t AluSub = 4'd1;
  localparam alu_op_t AluAnd = 4'd2;
  localparam alu_op_t AluOr  = 4'd3;
  localparam alu_op_t AluXor = 4'd4;
  localparam alu_op_t AluSll = 4'd5;
  localparam alu_op_t AluSrl = 4'd6;

  // Machine CSR numbers
  localparam csr_addr_t CsrMscratch = 12'h340;
  localparam csr_addr_t CsrMhartid  = 12'hF14;

  ////////////////////
  // Instruction word
  ////////////////////

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
  } rv_instr_u;

endpackage

/* logic/rv_if_stage.sv */
// Instruction fetch stage
// Holds the program counter, raises one fetch strobe per request
// and hands the returned instruction word to decode
`timescale 1ns/1ps

module rv_if_stage import rv_core_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  xlen_t boot_addr_i,
  input  logic  fetch_start_i,

  output logic  instr_req_o,
  output xlen_t instr_addr_o,
  input  logic  instr_rvalid_i,
  input  xlen_t instr_rdata_i,

  output logic  instr_valid_o,
  output xlen_t instr_o
);

  xlen_t pc_q;
  logic  req_q;
  logic  pending_q;
  xlen_t instr_q;

  // Strobe follows the start pulse by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q     <= 1'b0;
      pending_q <= 1'b0;
      pc_q      <= boot_addr_i;
    end else begin
      req_q <= fetch_start_i;
      if (req_q) begin
        pending_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        pending_q <= 1'b0;
      end
      // Sequential fetch only
      if (instr_valid_o) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_o) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o   = req_q;
  assign instr_addr_o  = pc_q;
  assign instr_valid_o = instr_rvalid_i & pending_q;

  // Word passes straight through on the answer cycle, then comes from the latch
  assign instr_o = instr_valid_o ? instr_rdata_i : instr_q;

endmodule

/* logic/rv_id_stage.sv */
// Decode and control stage
// Decodes the reduced RV32I subset, sequences fetch, execute and memory
// phases and selects the register writeback value
`timescale 1ns/1ps

module rv_id_stage import rv_core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      fetch_enable_i,
  input  logic      instr_valid_i,
  input  xlen_t     instr_i,
  output logic      fetch_start_o,

  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  output reg_addr_t rd_addr_o,
  output logic      rd_we_o,
  output xlen_t     rd_wdata_o,
  input  xlen_t     rs1_data_i,
  input  xlen_t     rs2_data_i,

  output alu_op_t   alu_op_o,
  output xlen_t     alu_operand_a_o,
  output xlen_t     alu_operand_b_o,
  input  xlen_t     alu_result_i,

  output logic      lsu_start_o,
  output logic      lsu_we_o,
  input  logic      lsu_done_i,
  input  xlen_t     lsu_rdata_i,

  output logic      csr_we_o,
  output csr_addr_t csr_addr_o,
  input  xlen_t     csr_rdata_i
);

  localparam logic [1:0] StIdle      = 2'd0;
  localparam logic [1:0] StFetchWait = 2'd1;
  localparam logic [1:0] StExecute   = 2'd2;
  localparam logic [1:0] StMemWait   = 2'd3;

  rv_instr_u  instr;
  logic [1:0] state_q;
  logic [1:0] state_d;
  xlen_t      imm;
  logic       use_rs2;
  logic       writes_rd;
  logic       is_load;
  logic       is_store;
  logic       is_csr;

  function automatic alu_op_t decode_alu_op(logic [2:0] funct3, logic sub);
    alu_op_t op;
    case (funct3)
      Funct3AddSub: op = sub ? AluSub : AluAdd;
      Funct3Sll:    op = AluSll;
      Funct3Xor:    op = AluXor;
      Funct3Srl:    op = AluSrl;
      Funct3Or:     op = AluOr;
      Funct3And:    op = AluAnd;
      default:      op = AluAdd;
    endcase
    return op;
  endfunction

  assign instr = instr_i;

  ////////////////////
  // Decoder
  ////////////////////

  always_comb begin
    alu_op_o  = AluAdd;
    imm       = {{20{instr.i.imm[11]}}, instr.i.imm};
    use_rs2   = 1'b0;
    writes_rd = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_csr    = 1'b0;
    case (instr.r.opcode)
      OpcodeOpImm: begin
        alu_op_o  = decode_alu_op(instr.i.funct3, 1'b0);
        writes_rd = 1'b1;
      end
      OpcodeOp: begin
        alu_op_o  = decode_alu_op(instr.r.funct3, instr.r.funct7 == Funct7Sub);
        use_rs2   = 1'b1;
        writes_rd = 1'b1;
      end
      OpcodeLoad: begin
        is_load   = instr.i.funct3 == Funct3Word;
        writes_rd = is_load;
      end
      OpcodeStore: begin
        imm      = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
        is_store = instr.s.funct3 == Funct3Word;
      end
      OpcodeSystem: begin
        is_csr    = instr.i.funct3 == Funct3Csrrw;
        writes_rd = is_csr;
      end
      // Anything else falls through as a no-op
      default: ;
    endcase
  end

  assign rs1_addr_o      = instr.r.rs1;
  assign rs2_addr_o      = instr.r.rs2;
  assign rd_addr_o       = instr.r.rd;
  assign alu_operand_a_o = rs1_data_i;
  assign alu_operand_b_o = use_rs2 ? rs2_data_i : imm;
  assign lsu_we_o        = is_store;
  assign csr_addr_o      = instr.i.imm;

  // Load data only ends the memory phase, CSRRW returns the old value
  always_comb begin
    if (state_q == StMemWait) begin
      rd_wdata_o = lsu_rdata_i;
    end else if (is_csr) begin
      rd_wdata_o = csr_rdata_i;
    end else begin
      rd_wdata_o = alu_result_i;
    end
  end

  ////////////////////
  // Sequencer
  ////////////////////

  always_comb begin
    state_d       = state_q;
    fetch_start_o = 1'b0;
    lsu_start_o   = 1'b0;
    rd_we_o       = 1'b0;
    csr_we_o      = 1'b0;
    case (state_q)
      StIdle: begin
        if (fetch_enable_i) begin
          fetch_start_o = 1'b1;
          state_d       = StFetchWait;
        end
      end
      StFetchWait: begin
        // Memory ops leave on the answer cycle so the data strobe follows next
        if (instr_valid_i) begin
          lsu_start_o = is_load | is_store;
          state_d     = (is_load | is_store) ? StMemWait : StExecute;
        end
      end
      StExecute: begin
        rd_we_o       = writes_rd;
        csr_we_o      = is_csr;
        fetch_start_o = 1'b1;
        state_d       = StFetchWait;
      end
      default: begin
        if (lsu_done_i) begin
          rd_we_o       = is_load;
          fetch_start_o = 1'b1;
          state_d       = StFetchWait;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* logic/rv_regfile.sv */
// Integer register file
// Two combinational read ports and one write port, x0 tied to zero
`timescale 1ns/1ps

module rv_regfile import rv_core_pkg::*; #(
  parameter int unsigned NumRegs = 32
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  logic      we_i,
  input  xlen_t     wdata_i,
  output xlen_t     rdata_a_o,
  output xlen_t     rdata_b_o
);

  xlen_t regs_q [NumRegs];

  // x0 and indices past the implemented set are never written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0) && (waddr_i < NumRegs)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = ((raddr_a_i != '0) && (raddr_a_i < NumRegs)) ? regs_q[raddr_a_i] : '0;
  assign rdata_b_o = ((raddr_b_i != '0) && (raddr_b_i < NumRegs)) ? regs_q[raddr_b_i] : '0;

endmodule

/* logic/rv_alu.sv */
// Integer ALU
// Add, subtract, logic and logical shifts on 32-bit operands
// The shared adder also produces load/store addresses
`timescale 1ns/1ps

module rv_alu import rv_core_pkg::*; (
  input  alu_op_t op_i,
  input  xlen_t   operand_a_i,
  input  xlen_t   operand_b_i,
  output xlen_t   result_o
);

  logic       sub;
  xlen_t      adder_b;
  xlen_t      adder_result;
  logic [4:0] shamt;

  // Subtract as a + ~b + 1 through the same adder
  assign sub          = op_i == AluSub;
  assign adder_b      = sub ? ~operand_b_i : operand_b_i;
  assign adder_result = operand_a_i + adder_b + {31'b0, sub};

  assign shamt = operand_b_i[4:0];

  always_comb begin
    case (op_i)
      AluAdd,
      AluSub: result_o = adder_result;
      AluAnd: result_o = operand_a_i & operand_b_i;
      AluOr:  result_o = operand_a_i | operand_b_i;
      AluXor: result_o = operand_a_i ^ operand_b_i;
      AluSll: result_o = operand_a_i << shamt;
      AluSrl: result_o = operand_a_i >> shamt;
      default: result_o = adder_result;
    endcase
  end

endmodule

/* logic/rv_lsu.sv */
// Word load/store unit
// Registers the request, raises one data strobe and waits for the answer
// Load data is captured and held for writeback
`timescale 1ns/1ps

module rv_lsu import rv_core_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  start_i,
  input  logic  we_i,
  input  xlen_t addr_i,
  input  xlen_t wdata_i,

  // Data bus
  output logic  data_req_o,
  output logic  data_we_o,
  output xlen_t data_addr_o,
  output xlen_t data_wdata_o,
  input  logic  data_rvalid_i,
  input  xlen_t data_rdata_i,

  output logic  done_o,
  output xlen_t rdata_o
);

  logic  req_q;
  logic  pending_q;
  logic  we_q;
  xlen_t addr_q;
  xlen_t wdata_q;
  xlen_t rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q     <= 1'b0;
      pending_q <= 1'b0;
      we_q      <= 1'b0;
    end else begin
      req_q <= start_i;
      if (start_i) begin
        we_q <= we_i;
      end
      // Busy from the strobe until the single answer
      if (req_q) begin
        pending_q <= 1'b1;
      end else if (data_rvalid_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (done_o && !we_q) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o   = req_q;
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  assign done_o  = data_rvalid_i & pending_q;
  assign rdata_o = done_o ? data_rdata_i : rdata_q;

endmodule

/* logic/rv_csr.sv */
// Machine control and status registers
// mscratch is read/write, mhartid reports the core id
// Unimplemented numbers read zero and drop writes
`timescale 1ns/1ps

module rv_csr import rv_core_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [3:0] core_id_i,
  input  logic       we_i,
  input  csr_addr_t  addr_i,
  input  xlen_t      wdata_i,
  output xlen_t      rdata_o
);

  xlen_t mscratch_q;

  // Write lands at the edge, so the same cycle still reads the old value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mscratch_q <= '0;
    end else if (we_i && (addr_i == CsrMscratch)) begin
      mscratch_q <= wdata_i;
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  always_comb begin
    case (addr_i)
      CsrMscratch: rdata_o = mscratch_q;
      CsrMhartid:  rdata_o = {28'b0, core_id_i};
      default:     rdata_o = '0;
    endcase
  end

endmodule

/* logic/rv_core.sv */
// Multi-cycle RV32I core, top level
// Runs one instruction at a time: fetch, decode, execute, memory, writeback
// Strobe based instruction and data buses without back-pressure
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; #(
  parameter int unsigned NumRegs = 32
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fetch_enable_i,
  input  logic [3:0] core_id_i,
  input  xlen_t      boot_addr_i,

  // Instruction bus
  output logic       instr_req_o,
  output xlen_t      instr_addr_o,
  input  logic       instr_rvalid_i,
  input  xlen_t      instr_rdata_i,

  // Data bus
  output logic       data_req_o,
  output logic       data_we_o,
  output xlen_t      data_addr_o,
  output xlen_t      data_wdata_o,
  input  logic       data_rvalid_i,
  input  xlen_t      data_rdata_i
);

  // Fetch to decode
  logic      fetch_start;
  logic      instr_valid;
  xlen_t     instr;

  // Register file
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  logic      rd_we;
  xlen_t     rd_wdata;
  xlen_t     rs1_data;
  xlen_t     rs2_data;

  // Execute
  alu_op_t   alu_op;
  xlen_t     alu_operand_a;
  xlen_t     alu_operand_b;
  xlen_t     alu_result;

  // Load/store and CSR
  logic      lsu_start;
  logic      lsu_we;
  logic      lsu_done;
  xlen_t     lsu_rdata;
  logic      csr_we;
  csr_addr_t csr_addr;
  xlen_t     csr_rdata;

  //////////////////////
  // Fetch and decode
  //////////////////////

  rv_if_stage u_if_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr_i),
    .fetch_start_i  (fetch_start),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_valid_o  (instr_valid),
    .instr_o        (instr)
  );

  rv_id_stage u_id_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .fetch_enable_i  (fetch_enable_i),
    .instr_valid_i   (instr_valid),
    .instr_i         (instr),
    .fetch_start_o   (fetch_start),
    .rs1_addr_o      (rs1_addr),
    .rs2_addr_o      (rs2_addr),
    .rd_addr_o       (rd_addr),
    .rd_we_o         (rd_we),
    .rd_wdata_o      (rd_wdata),
    .rs1_data_i      (rs1_data),
    .rs2_data_i      (rs2_data),
    .alu_op_o        (alu_op),
    .alu_operand_a_o (alu_operand_a),
    .alu_operand_b_o (alu_operand_b),
    .alu_result_i    (alu_result),
    .lsu_start_o     (lsu_start),
    .lsu_we_o        (lsu_we),
    .lsu_done_i      (lsu_done),
    .lsu_rdata_i     (lsu_rdata),
    .csr_we_o        (csr_we),
    .csr_addr_o      (csr_addr),
    .csr_rdata_i     (csr_rdata)
  );

  rv_regfile #(
    .NumRegs (NumRegs)
  ) u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .waddr_i   (rd_addr),
    .we_i      (rd_we),
    .wdata_i   (rd_wdata),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  //////////////////////
  // Execute, memory, CSR
  //////////////////////

  rv_alu u_alu (
    .op_i        (alu_op),
    .operand_a_i (alu_operand_a),
    .operand_b_i (alu_operand_b),
    .result_o    (alu_result)
  );

  // Adder output is the load/store address, rs2 the store data
  rv_lsu u_lsu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (lsu_start),
    .we_i          (lsu_we),
    .addr_i        (alu_result),
    .wdata_i       (rs2_data),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .done_o        (lsu_done),
    .rdata_o       (lsu_rdata)
  );

  // CSRRW writes rs1 into the CSR
  rv_csr u_csr (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .core_id_i (core_id_i),
    .we_i      (csr_we),
    .addr_i    (csr_addr),
    .wdata_i   (rs1_data),
    .rdata_o   (csr_rdata)
  );

endmodule

/* tests/rv_core_sva.sv */
// Bus strobe protocol assertions for the multi-cycle core
// Strobes stay low in reset, never overlap and last a single cycle
`timescale 1ns/1ps

module rv_core_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_req_i,
  input logic data_req_i,
  input logic rd_we_i,
  input logic csr_we_i
);

  int unsigned assert_fails = 0;

  // Nothing fires while the core is held in reset
  strobes_low_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !(instr_req_i || data_req_i || rd_we_i || csr_we_i))
  else begin
    $error("strobe or write enable high during reset");
    assert_fails++;
  end

  // One instruction in flight, so the buses never overlap
  buses_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(instr_req_i && data_req_i))
  else begin
    $error("instr_req_o and data_req_o high together");
    assert_fails++;
  end

  instr_req_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i |=> !instr_req_i)
  else begin
    $error("instr_req_o held longer than one cycle");
    assert_fails++;
  end

  data_req_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_i |=> !data_req_i)
  else begin
    $error("data_req_o held longer than one cycle");
    assert_fails++;
  end

endmodule

bind rv_core rv_core_sva u_rv_core_sva (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .instr_req_i (instr_req_o),
  .data_req_i  (data_req_o),
  .rd_we_i     (rd_we),
  .csr_we_i    (csr_we)
);

/* tests/rv_core_tb.sv */
// Testbench for the multi-cycle RV32I core
// Runs a table of short programs against instruction and data memory
// models with random answer latency and checks the final store of each
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ();

  localparam int    ClkPeriod = 100;
  localparam int    NumTests  = 7;
  localparam int    MaxInstr  = 8;
  localparam int    Seed      = 66437;
  localparam int    TimeoutNs = NumTests * MaxInstr * 12 * ClkPeriod;
  localparam xlen_t Nop       = 32'h0000_0013;

  logic       clk_i;
  logic       rst_ni;
  logic       fetch_enable_i;
  logic [3:0] core_id_i;
  xlen_t      boot_addr_i;
  logic       instr_req_o;
  xlen_t      instr_addr_o;
  logic       instr_rvalid_i;
  xlen_t      instr_rdata_i;
  logic       data_req_o;
  logic       data_we_o;
  xlen_t      data_addr_o;
  xlen_t      data_wdata_o;
  logic       data_rvalid_i;
  xlen_t      data_rdata_i;

  // Test table
  string      tbl_name     [NumTests];
  xlen_t      tbl_boot     [NumTests];
  logic [3:0] tbl_id       [NumTests];
  int         tbl_n        [NumTests];
  xlen_t      tbl_prog     [NumTests][MaxInstr];
  xlen_t      tbl_daddr    [NumTests];
  xlen_t      tbl_ddata    [NumTests];
  xlen_t      tbl_exp_addr [NumTests];
  xlen_t      tbl_exp_data [NumTests];
  int         num_tests;

  // Memory model state for the running test
  xlen_t cur_boot;
  int    cur_n;
  xlen_t cur_prog [MaxInstr];
  xlen_t cur_daddr;
  xlen_t cur_ddata;
  xlen_t expected_pc;
  int    fetch_count;
  logic  last_we;
  xlen_t last_addr;
  xlen_t last_wdata;
  int    error_count;
  int    failed_tests;

  rv_core #(
    .NumRegs (32)
  ) u_rv_core (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .core_id_i      (core_id_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .data_req_o     (data_req_o),
    .data_we_o      (data_we_o),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////
  // Encoders
  ////////////////////

  function automatic xlen_t itype(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                 reg_addr_t rd, logic [6:0] opcode);
    rv_instr_u w;
    w.i.imm    = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = opcode;
    return w;
  endfunction

  function automatic xlen_t alu_rr(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                   reg_addr_t rs1, reg_addr_t rs2);
    rv_instr_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = OpcodeOp;
    return w;
  endfunction

  // Store splits the offset around rs1/rs2
  function automatic xlen_t sw(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
    rv_instr_u w;
    w.s.imm_hi = imm[11:5];
    w.s.rs2    = rs2;
    w.s.rs1    = rs1;
    w.s.funct3 = 3'b010;
    w.s.imm_lo = imm[4:0];
    w.s.opcode = OpcodeStore;
    return w;
  endfunction

  function automatic xlen_t addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    return itype(imm, rs1, 3'b000, rd, OpcodeOpImm);
  endfunction

  function automatic xlen_t lw(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    return itype(imm, rs1, 3'b010, rd, OpcodeLoad);
  endfunction

  function automatic xlen_t csrrw(reg_addr_t rd, csr_addr_t csr, reg_addr_t rs1);
    return itype(csr, rs1, 3'b001, rd, OpcodeSystem);
  endfunction

  ////////////////////
  // Memory contents
  ////////////////////

  function automatic xlen_t fetch_word(xlen_t addr);
    xlen_t idx;
    idx = (addr - cur_boot) >> 2;
    if (addr >= cur_boot && idx < cur_n) begin
      return cur_prog[idx];
    end
    return Nop;
  endfunction

  // Unwritten data words mix all address bits
  function automatic xlen_t load_word(xlen_t addr);
    if (addr == cur_daddr) begin
      return cur_ddata;
    end
    return {addr[15:0], addr[31:16]} ^ 32'h6C3A_95E1;
  endfunction

  task automatic check_word(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  ////////////////////
  // Test table
  ////////////////////

  task automatic new_test(string name, xlen_t boot, logic [3:0] id, xlen_t daddr,
                          xlen_t ddata, xlen_t exp_addr, xlen_t exp_data);
    tbl_name[num_tests]     = name;
    tbl_boot[num_tests]     = boot;
    tbl_id[num_tests]       = id;
    tbl_daddr[num_tests]    = daddr;
    tbl_ddata[num_tests]    = ddata;
    tbl_exp_addr[num_tests] = exp_addr;
    tbl_exp_data[num_tests] = exp_data;
    tbl_n[num_tests]        = 0;
    num_tests++;
  endtask

  task automatic push_instr(xlen_t word);
    tbl_prog[num_tests-1][tbl_n[num_tests-1]] = word;
    tbl_n[num_tests-1]++;
  endtask

  task automatic build_table();
    // 0x120 + (-5) stored at 0x120 + 0x40
    new_test("addi_add", 32'h0000_1000, 4'h0, 32'h0, 32'h0, 32'h0000_0160, 32'h0000_011B);
    push_instr(addi(1, 0, 12'h120));
    push_instr(addi(2, 0, 12'hFFB));
    push_instr(alu_rr(7'h00, 3'b000, 3, 1, 2));
    push_instr(sw(3, 1, 12'h040));
    // 0x5A5 - 0x30F = 0x296, ^0x30F = 0x199, |0x5A5 = 0x5BD, &0x30F = 0x10D
    new_test("sub_logic", 32'h0000_2000, 4'h0, 32'h0, 32'h0, 32'h0000_0200, 32'h0000_010D);
    push_instr(addi(1, 0, 12'h5A5));
    push_instr(addi(2, 0, 12'h30F));
    push_instr(alu_rr(7'h20, 3'b000, 3, 1, 2));
    push_instr(alu_rr(7'h00, 3'b100, 4, 3, 2));
    push_instr(alu_rr(7'h00, 3'b110, 5, 4, 1));
    push_instr(alu_rr(7'h00, 3'b111, 6, 5, 2));
    push_instr(sw(6, 0, 12'h200));
    // Shift amount 36 uses its low five bits only
    new_test("shifts", 32'h0000_0100, 4'h0, 32'h0, 32'h0, 32'h0000_0308, 32'h0FFF_FFFF);
    push_instr(addi(1, 0, 12'hFFF));
    push_instr(addi(2, 0, 12'h024));
    push_instr(alu_rr(7'h00, 3'b001, 3, 1, 2));
    push_instr(alu_rr(7'h00, 3'b101, 4, 3, 2));
    push_instr(addi(5, 0, 12'h300));
    push_instr(sw(4, 5, 12'h008));
    // Negative load offset, word copied to 0x44 + 0x10
    new_test("load_store", 32'h0000_0400, 4'h0, 32'h0000_0080, 32'hDEAD_BEEF,
             32'h0000_0054, 32'hDEAD_BEEF);
    push_instr(addi(1, 0, 12'h084));
    push_instr(lw(2, 1, 12'hFFC));
    push_instr(addi(3, 0, 12'h044));
    push_instr(sw(2, 3, 12'h010));
    // Old mscratch (zero) forms the address, second swap returns 0x2AB
    new_test("mscratch", 32'h0000_0800, 4'h0, 32'h0, 32'h0, 32'h0000_0100, 32'h0000_02AB);
    push_instr(addi(5, 0, 12'h2AB));
    push_instr(csrrw(1, CsrMscratch, 5));
    push_instr(csrrw(2, CsrMscratch, 0));
    push_instr(sw(2, 1, 12'h100));
    new_test("mhartid", 32'h0000_3000, 4'hA, 32'h0, 32'h0, 32'h0000_0040, 32'h0000_000A);
    push_instr(addi(2, 0, 12'h7FF));
    push_instr(csrrw(0, CsrMhartid, 2));
    push_instr(csrrw(1, CsrMhartid, 2));
    push_instr(sw(1, 0, 12'h040));
    // ALU, load and immediate writes to x0 all vanish
    new_test("x0_discard", 32'h0000_1800, 4'h0, 32'h0000_0060, 32'h1234_5678,
             32'h0000_0064, 32'h0000_0000);
    push_instr(addi(0, 0, 12'h555));
    push_instr(addi(1, 0, 12'h060));
    push_instr(lw(0, 1, 12'h000));
    push_instr(alu_rr(7'h00, 3'b000, 0, 1, 1));
    push_instr(sw(0, 1, 12'h004));
  endtask

  ////////////////////
  // Memory models
  ////////////////////

  always begin : instr_memory
    int    lat;
    xlen_t addr;
    @(negedge clk_i);
    if (instr_req_o) begin
      addr = instr_addr_o;
      check_word("instr_addr_o", addr, expected_pc);
      expected_pc = expected_pc + 32'd4;
      fetch_count++;
      lat = $urandom % 3 + 1;
      repeat (lat) @(negedge clk_i);
      instr_rdata_i  = fetch_word(addr);
      instr_rvalid_i = 1'b1;
      @(negedge clk_i);
      instr_rvalid_i = 1'b0;
    end
  end

  always begin : data_memory
    int lat;
    @(negedge clk_i);
    if (data_req_o) begin
      last_we    = data_we_o;
      last_addr  = data_addr_o;
      last_wdata = data_wdata_o;
      lat = $urandom % 3 + 1;
      repeat (lat) @(negedge clk_i);
      data_rdata_i  = load_word(last_addr);
      data_rvalid_i = 1'b1;
      @(negedge clk_i);
      data_rvalid_i = 1'b0;
    end
  end

  // Called on a falling edge; resets the core and runs one table entry
  task automatic run_test(int t);
    int errors_before;
    fetch_enable_i = 1'b0;
    boot_addr_i    = tbl_boot[t];
    core_id_i      = tbl_id[t];
    rst_ni         = 1'b0;
    cur_boot       = tbl_boot[t];
    cur_n          = tbl_n[t];
    cur_daddr      = tbl_daddr[t];
    cur_ddata      = tbl_ddata[t];
    for (int i = 0; i < tbl_n[t]; i++) begin
      cur_prog[i] = tbl_prog[t][i];
    end
    repeat (3) @(negedge clk_i);
    rst_ni        = 1'b1;
    expected_pc   = tbl_boot[t];
    fetch_count   = 0;
    errors_before = error_count;
    // Let any answer still in flight from the last program drain
    repeat (2) @(negedge clk_i);
    fetch_enable_i = 1'b1;
    // The fetch past the last instruction means the final store is done
    wait (fetch_count > tbl_n[t]);
    check_flag("data_we_o", last_we, 1'b1);
    check_word("data_addr_o", last_addr, tbl_exp_addr[t]);
    check_word("data_wdata_o", last_wdata, tbl_exp_data[t]);
    if (error_count == errors_before) begin
      $display("Test %0d %s: ok", t, tbl_name[t]);
    end else begin
      failed_tests++;
      $display("Test %0d %s: %0d errors", t, tbl_name[t], error_count - errors_before);
    end
    @(negedge clk_i);
  endtask

  initial begin : main
    int sva_fails;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    core_id_i      = '0;
    boot_addr_i    = '0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    error_count    = 0;
    failed_tests   = 0;
    fetch_count    = 0;
    expected_pc    = '0;
    num_tests      = 0;
    void'($urandom(Seed));
    build_table();
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    sva_fails = u_rv_core.u_rv_core_sva.assert_fails;
    $display("Tests run: %0d, failed: %0d, check errors: %0d, assertion failures: %0d",
             num_tests, failed_tests, error_count, sva_fails);
    if (failed_tests == 0 && error_count == 0 && sva_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    #(TimeoutNs);
    $display("Timeout: the test table did not finish within %0d ns", TimeoutNs);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* build.f */
logic/rv_core_pkg.sv
logic/rv_if_stage.sv
logic/rv_id_stage.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_lsu.sv
logic/rv_csr.sv
logic/rv_core.sv
tests/rv_core_sva.sv
tests/rv_core_tb.sv
